/* design/spi_defs.svh */
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// ====================
// Register map
// ====================

// One 32-bit word per register
`define SPI_ADDR_CTRL   32'h8000_0050
`define SPI_ADDR_DATA   32'h8000_0054
`define SPI_ADDR_STATUS 32'h8000_0058
`define SPI_ADDR_CS     32'h8000_005C
`define SPI_ADDR_BURST  32'h8000_0060

// ====================
// Widths
// ====================

// One SPI byte
`define SPI_DATA_W 8
// Divider select, /1 up to /128
`define SPI_DIV_W 3
// Divider counter, wide enough for 2^7 - 1
`define SPI_CNT_W 7
// Burst byte counter
`define SPI_BURST_W 13

// Reset divider select, /128 for slow card init
`define SPI_CLK_DIV_RST 3'd7

`endif

/* design/spi_pkg.sv */
`include "spi_defs.svh"

package spi_pkg;

    // ====================
    // Channel configuration
    // ====================

    // Packed so the struct matches CTRL bits [4:0]
    // cpol in bit 0, cpha in bit 1, divider in bits [4:2]
    typedef struct packed {
        logic [`SPI_DIV_W-1:0] clk_div;
        logic                  cpha;
        logic                  cpol;
    } spi_cfg_t;

    // ====================
    // Register bus
    // ====================

    // Request side, held by the requester until ready
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mmio_req_t;

    // Response side
    // ready is a single-cycle acknowledge
    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } mmio_rsp_t;

    // Outgoing SPI pins
    typedef struct packed {
        logic sck;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    // Bit engine states
    typedef enum logic [1:0] {
        SPI_IDLE     = 2'b00,
        SPI_TRANSMIT = 2'b01,
        SPI_FINISH   = 2'b10
    } spi_state_e;

endpackage

/* design/spi_clk_div.sv */
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_clk_div (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [`SPI_DIV_W-1:0] clk_div,
    output logic                  sclk_en
);

    localparam logic [`SPI_CNT_W-1:0] CNT_ONE = 1;

    logic [`SPI_CNT_W-1:0] cnt;
    logic [`SPI_CNT_W-1:0] threshold;

    // Terminal count is 2^clk_div - 1
    // select 0 gives an enable every cycle
    assign threshold = (CNT_ONE << clk_div) - CNT_ONE;

    // ====================
    // Free-running counter
    // ====================

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt     <= '0;
            sclk_en <= 1'b0;
        end else begin
            if (cnt >= threshold) begin
                // Match, one enable pulse then restart
                // >= also recovers when the divider shrinks mid-count
                sclk_en <= 1'b1;
                cnt     <= '0;
            end else begin
                sclk_en <= 1'b0;
                cnt     <= cnt + CNT_ONE;
            end
        end
    end

endmodule

/* design/spi_shift_engine.sv */
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_shift_engine (
    input  logic                   clk,
    input  logic                   resetn,
    input  spi_pkg::spi_cfg_t      cfg,
    input  logic                   sclk_en,
    input  logic                   start,
    input  logic [`SPI_DATA_W-1:0] tx_byte,
    input  logic                   miso,
    output logic                   sck,
    output logic                   mosi,
    output logic                   busy,
    output logic                   byte_done,
    output logic [`SPI_DATA_W-1:0] rx_byte
);

    localparam int MSB   = `SPI_DATA_W - 1;
    localparam int BIT_W = $clog2(`SPI_DATA_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`SPI_DATA_W - 1);

    spi_pkg::spi_state_e state;

    // Bit index within the byte
    logic [BIT_W-1:0] bit_cnt;
    // 0 before the leading edge, 1 before the trailing edge
    logic             sck_phase;
    // TX bits leave at the top, RX bits enter at the bottom
    logic [MSB:0]     shift_q;
    // MISO held from the leading edge in CPHA 0
    logic             miso_cap;

    logic lead_edge;
    logic trail_edge;
    logic last_bit;

    assign lead_edge  = (state == spi_pkg::SPI_TRANSMIT) && sclk_en && !sck_phase;
    assign trail_edge = (state == spi_pkg::SPI_TRANSMIT) && sclk_en && sck_phase;
    assign last_bit   = (bit_cnt == LAST_BIT);

    // ====================
    // FSM and pins
    // ====================

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= spi_pkg::SPI_IDLE;
            sck       <= 1'b0;
            mosi      <= 1'b0;
            bit_cnt   <= '0;
            sck_phase <= 1'b0;
        end else begin
            case (state)
                spi_pkg::SPI_IDLE: begin
                    // Clock parked at its idle level
                    sck       <= cfg.cpol;
                    sck_phase <= 1'b0;
                    bit_cnt   <= '0;
                    if (start) begin
                        state <= spi_pkg::SPI_TRANSMIT;
                        // CPHA 0 needs data before the first edge
                        if (!cfg.cpha) begin
                            mosi <= tx_byte[MSB];
                        end
                    end
                end

                spi_pkg::SPI_TRANSMIT: begin
                    if (sclk_en) begin
                        sck_phase <= ~sck_phase;
                        // Leading edge leaves cpol, trailing edge returns
                        sck <= sck_phase ? cfg.cpol : ~cfg.cpol;

                        if (!sck_phase) begin
                            // Leading edge, CPHA 1 sets up here
                            if (cfg.cpha) begin
                                mosi <= shift_q[MSB];
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // Trailing edge, CPHA 0 drives the next bit
                            // shift_q still holds the old order here
                            if (!cfg.cpha && !last_bit) begin
                                mosi <= shift_q[MSB-1];
                            end
                            if (last_bit) begin
                                state <= spi_pkg::SPI_FINISH;
                            end
                        end
                    end
                end

                spi_pkg::SPI_FINISH: begin
                    // One cycle, clock back to idle
                    sck   <= cfg.cpol;
                    state <= spi_pkg::SPI_IDLE;
                end

                default: begin
                    state <= spi_pkg::SPI_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Shift register
    // ====================

    always_ff @(posedge clk) begin
        if ((state == spi_pkg::SPI_IDLE) && start) begin
            shift_q <= tx_byte;
        end else if (lead_edge && !cfg.cpha) begin
            // Sample only, shift on the trailing edge
            miso_cap <= miso;
        end else if (trail_edge) begin
            shift_q <= {shift_q[MSB-1:0], cfg.cpha ? miso : miso_cap};
        end
    end

    // Status toward the register block
    assign busy      = (state != spi_pkg::SPI_IDLE);
    assign byte_done = (state == spi_pkg::SPI_FINISH);
    // Full received byte once in finish
    assign rx_byte   = shift_q;

endmodule

/* design/spi_regs.sv */
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_regs (
    input  logic                   clk,
    input  logic                   resetn,
    input  spi_pkg::mmio_req_t     mmio_req,
    output spi_pkg::mmio_rsp_t     mmio_rsp,
    output spi_pkg::spi_cfg_t      cfg,
    output logic                   start,
    output logic [`SPI_DATA_W-1:0] tx_byte,
    input  logic                   eng_busy,
    input  logic                   byte_done,
    input  logic [`SPI_DATA_W-1:0] rx_byte,
    output logic                   cs_n,
    output logic                   spi_irq
);

    localparam int CFG_W = $bits(spi_pkg::spi_cfg_t);
    localparam logic [`SPI_BURST_W-1:0] BURST_ONE = 1;

    // Configuration and chip select
    spi_pkg::spi_cfg_t cfg_q;
    logic              cs_q;

    // Data path registers
    logic [`SPI_DATA_W-1:0] tx_q;
    logic [`SPI_DATA_W-1:0] rx_q;
    logic                   start_q;

    // Burst tracking
    logic [`SPI_BURST_W-1:0] burst_cnt;
    logic                    burst_act;

    logic        irq_q;
    logic        ready_q;
    logic [31:0] rdata_q;

    // Pending start counts as busy, engine not yet out of idle
    logic chan_busy;
    logic req_new;

    assign chan_busy = start_q | eng_busy;
    // New request, not the cycle already being acknowledged
    assign req_new   = mmio_req.valid && !ready_q;

    // ====================
    // Bus decode
    // ====================

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ready_q   <= 1'b0;
            start_q   <= 1'b0;
            cfg_q     <= '{clk_div: `SPI_CLK_DIV_RST, cpha: 1'b0, cpol: 1'b0};
            cs_q      <= 1'b1;
            burst_cnt <= '0;
            burst_act <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            // Pulses by default
            ready_q <= 1'b0;
            start_q <= 1'b0;
            irq_q   <= 1'b0;

            // Byte complete, burst bookkeeping and IRQ
            if (byte_done) begin
                if (!burst_act) begin
                    irq_q <= 1'b1;
                end else if (burst_cnt == BURST_ONE) begin
                    // Last byte of the burst
                    burst_act <= 1'b0;
                    burst_cnt <= '0;
                    irq_q     <= 1'b1;
                end else begin
                    burst_cnt <= burst_cnt - BURST_ONE;
                end
            end

            // Bus writes come after and win on a collision
            if (req_new && mmio_req.write) begin
                case (mmio_req.addr)
                    `SPI_ADDR_CTRL: begin
                        if (mmio_req.wstrb[0]) begin
                            cfg_q <= spi_pkg::spi_cfg_t'(mmio_req.wdata[CFG_W-1:0]);
                        end
                        ready_q <= 1'b1;
                    end

                    `SPI_ADDR_DATA: begin
                        // Held off while the channel is busy
                        if (!chan_busy) begin
                            if (mmio_req.wstrb[0]) begin
                                start_q <= 1'b1;
                            end
                            ready_q <= 1'b1;
                        end
                    end

                    `SPI_ADDR_CS: begin
                        if (mmio_req.wstrb[0]) begin
                            cs_q <= mmio_req.wdata[0];
                        end
                        ready_q <= 1'b1;
                    end

                    `SPI_ADDR_BURST: begin
                        // Count spans lanes 0 and 1
                        if (mmio_req.wstrb[0] || mmio_req.wstrb[1]) begin
                            burst_cnt <= mmio_req.wdata[`SPI_BURST_W-1:0];
                            burst_act <= |mmio_req.wdata[`SPI_BURST_W-1:0];
                        end
                        ready_q <= 1'b1;
                    end

                    // STATUS and unmapped writes just ack
                    default: begin
                        ready_q <= 1'b1;
                    end
                endcase
            end else if (req_new) begin
                // Reads always ack in one cycle
                ready_q <= 1'b1;
            end
        end
    end

    // ====================
    // Payload registers
    // ====================

    always_ff @(posedge clk) begin
        // Byte to send, taken with the start pulse
        if (req_new && mmio_req.write && (mmio_req.addr == `SPI_ADDR_DATA) &&
            !chan_busy && mmio_req.wstrb[0]) begin
            tx_q <= mmio_req.wdata[`SPI_DATA_W-1:0];
        end

        if (byte_done) begin
            rx_q <= rx_byte;
        end

        // Read mux, unmapped reads give zero
        if (req_new && !mmio_req.write) begin
            case (mmio_req.addr)
                `SPI_ADDR_CTRL:   rdata_q <= {{(32-CFG_W){1'b0}}, cfg_q};
                `SPI_ADDR_DATA:   rdata_q <= {{(32-`SPI_DATA_W){1'b0}}, rx_q};
                // busy, done, burst active
                `SPI_ADDR_STATUS: rdata_q <= {29'h0, burst_act, ~chan_busy, chan_busy};
                `SPI_ADDR_CS:     rdata_q <= {31'h0, cs_q};
                `SPI_ADDR_BURST:  rdata_q <= {{(32-`SPI_BURST_W){1'b0}}, burst_cnt};
                default:          rdata_q <= 32'h0;
            endcase
        end
    end

    assign mmio_rsp = '{rdata: rdata_q, ready: ready_q};
    assign cfg      = cfg_q;
    assign start    = start_q;
    assign tx_byte  = tx_q;
    assign cs_n     = cs_q;
    assign spi_irq  = irq_q;

endmodule

/* design/spi_master_top.sv */
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_master_top (
    input  logic               clk,
    input  logic               resetn,
    input  spi_pkg::mmio_req_t mmio_req,
    output spi_pkg::mmio_rsp_t mmio_rsp,
    input  logic               spi_miso,
    output spi_pkg::spi_pins_t spi_pins,
    output logic               spi_irq
);

    spi_pkg::spi_cfg_t cfg;

    // Register block to engine
    logic                   start;
    logic [`SPI_DATA_W-1:0] tx_byte;
    logic                   eng_busy;
    logic                   byte_done;
    logic [`SPI_DATA_W-1:0] rx_byte;

    logic sclk_en;
    logic sck;
    logic mosi;
    logic cs_n;

    // Register decode, burst and IRQ
    spi_regs i_spi_regs (
        .clk       (clk),
        .resetn    (resetn),
        .mmio_req  (mmio_req),
        .mmio_rsp  (mmio_rsp),
        .cfg       (cfg),
        .start     (start),
        .tx_byte   (tx_byte),
        .eng_busy  (eng_busy),
        .byte_done (byte_done),
        .rx_byte   (rx_byte),
        .cs_n      (cs_n),
        .spi_irq   (spi_irq)
    );

    // SCK half-period tick
    spi_clk_div i_spi_clk_div (
        .clk     (clk),
        .resetn  (resetn),
        .clk_div (cfg.clk_div),
        .sclk_en (sclk_en)
    );

    spi_shift_engine i_spi_shift_engine (
        .clk       (clk),
        .resetn    (resetn),
        .cfg       (cfg),
        .sclk_en   (sclk_en),
        .start     (start),
        .tx_byte   (tx_byte),
        .miso      (spi_miso),
        .sck       (sck),
        .mosi      (mosi),
        .busy      (eng_busy),
        .byte_done (byte_done),
        .rx_byte   (rx_byte)
    );

    // Chip select comes from the register block, not the engine
    assign spi_pins = '{sck: sck, mosi: mosi, cs_n: cs_n};

endmodule

/* sim/tb_spi_master.sv */
`timescale 1ns/10ps
`include "spi_defs.svh"

module tb_spi_master;

    localparam int BUS_TIMEOUT  = 5000;
    localparam int POLL_TIMEOUT = 3000;
    localparam int NUM_ROWS     = 9;

    // One transfer scenario, tx byte i sits in bits [8i+7:8i]
    // burst_n 0 means a single byte with no burst
    typedef struct packed {
        logic        cpol;
        logic        cpha;
        logic [2:0]  clk_div;
        logic [3:0]  burst_n;
        logic        rand_fill;
        logic [31:0] tx_bytes;
        logic [1:0]  exp_irq;
    } row_t;

    logic               clk = 1'b0;
    logic               resetn;
    spi_pkg::mmio_req_t mmio_req;
    spi_pkg::mmio_rsp_t mmio_rsp;
    spi_pkg::spi_pins_t spi_pins;
    logic               spi_irq;
    int                 irq_count;
    row_t               rows [NUM_ROWS];

    // Slave side capture of MOSI
    logic                   mode_cpol;
    logic                   mode_cpha;
    logic                   sck_prev;
    logic [`SPI_DATA_W-1:0] slave_rx;
    int                     slave_bits;

    always #4 clk = ~clk;

    // Loopback slave, MISO follows MOSI
    spi_master_top i_spi_master_top (
        .clk      (clk),
        .resetn   (resetn),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .spi_miso (spi_pins.mosi),
        .spi_pins (spi_pins),
        .spi_irq  (spi_irq)
    );

    // IRQ pulses counted mid-cycle
    always @(negedge clk) begin
        if (!resetn) begin
            irq_count <= 0;
        end else if (spi_irq) begin
            irq_count <= irq_count + 1;
        end
    end

    // MOSI shifted in MSB first on the SCK sampling edge
    // CPHA 0 samples as SCK leaves cpol, CPHA 1 as it returns
    always @(negedge clk) begin
        sck_prev <= spi_pins.sck;
        if (!resetn || spi_pins.cs_n) begin
            slave_bits <= 0;
        end else if ((spi_pins.sck !== sck_prev) &&
                     (spi_pins.sck === (mode_cpol ^ ~mode_cpha))) begin
            slave_rx   <= {slave_rx[`SPI_DATA_W-2:0], spi_pins.mosi};
            slave_bits <= slave_bits + 1;
        end
    end

    // ====================
    // Checks
    // ====================

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pins(input string what, input spi_pkg::spi_pins_t got,
                              input spi_pkg::spi_pins_t exp);
        // MOSI is don't care outside a transfer
        if (got.sck !== exp.sck || got.cs_n !== exp.cs_n) begin
            abort_run($sformatf("[FAIL] %0t: %s sck=%b cs_n=%b, expected sck=%b cs_n=%b",
                                $time, what, got.sck, got.cs_n, exp.sck, exp.cs_n));
        end
    endtask

    task automatic check_slave_byte(input string what, input logic [`SPI_DATA_W-1:0] got,
                                    input logic [`SPI_DATA_W-1:0] exp, input int bits,
                                    input int exp_bits);
        if (got !== exp || bits != exp_bits) begin
            abort_run($sformatf("[FAIL] %0t: %s got %h in %0d bits, expected %h in %0d bits",
                                $time, what, got, bits, exp, exp_bits));
        end
    endtask

    task automatic check_irq_count(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] %0t: %s saw %0d IRQs, expected %0d", $time, what, got, exp));
        end
    endtask

    // ====================
    // Bus access
    // ====================

    // Called and returns on a falling edge
    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb,
                              output logic [31:0] rdata);
        int waited;
        waited   = 0;
        mmio_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata, wstrb: wstrb};
        @(negedge clk);
        while (!mmio_rsp.ready) begin
            waited++;
            if (waited > BUS_TIMEOUT) begin
                abort_run($sformatf("Bus never acknowledged the access to %h", addr));
            end
            @(negedge clk);
        end
        rdata    = mmio_rsp.rdata;
        mmio_req = '0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, strb, unused);
    endtask

    task automatic read_check(input string what, input logic [31:0] addr,
                              input logic [31:0] exp);
        logic [31:0] got;
        bus_access(1'b0, addr, 32'h0, 4'h0, got);
        check_word(what, got, exp);
    endtask

    // Poll STATUS until the done bit is set
    task automatic wait_idle(output logic [31:0] status);
        int polls;
        polls = 0;
        bus_access(1'b0, `SPI_ADDR_STATUS, 32'h0, 4'h0, status);
        while (!status[1]) begin
            polls++;
            if (polls > POLL_TIMEOUT) begin
                abort_run("Channel stayed busy, STATUS done never set");
            end
            bus_access(1'b0, `SPI_ADDR_STATUS, 32'h0, 4'h0, status);
        end
    endtask

    // One table row, all bytes under one chip select
    task automatic run_row(input row_t r);
        int          n;
        int          base;
        logic        act;
        logic [31:0] st;
        logic [7:0]  tx;
        n         = (r.burst_n == 0) ? 1 : int'(r.burst_n);
        base      = irq_count;
        mode_cpol = r.cpol;
        mode_cpha = r.cpha;
        write_reg(`SPI_ADDR_CTRL, {27'h0, r.clk_div, r.cpha, r.cpol}, 4'h1);
        read_check("CTRL mode", `SPI_ADDR_CTRL, {27'h0, r.clk_div, r.cpha, r.cpol});
        write_reg(`SPI_ADDR_CS, 32'h0, 4'h1);
        check_pins("Idle before", spi_pins, '{sck: r.cpol, mosi: 1'b0, cs_n: 1'b0});
        if (r.burst_n != 0) begin
            write_reg(`SPI_ADDR_BURST, {28'h0, r.burst_n}, 4'h1);
        end
        for (int i = 0; i < n; i++) begin
            tx = r.tx_bytes[8*i +: 8];
            write_reg(`SPI_ADDR_DATA, {24'h0, tx}, 4'h1);
            wait_idle(st);
            act = (r.burst_n != 0) && (i + 1 < n);
            check_word("STATUS after byte", st, {29'h0, act, 2'b10});
            check_slave_byte("MOSI capture", slave_rx, tx, slave_bits, 8 * (i + 1));
            read_check("DATA loopback", `SPI_ADDR_DATA, {24'h0, tx});
            // Non-burst rows also expect 0 here
            read_check("BURST remaining", `SPI_ADDR_BURST, 32'(n - i - 1));
            if (i + 1 < n) begin
                check_irq_count("IRQ mid burst", irq_count, base);
            end
        end
        // Settle, a stray second pulse would show up here
        repeat (4) @(negedge clk);
        check_irq_count("IRQ per row", irq_count, base + r.exp_irq);
        check_pins("Idle after", spi_pins, '{sck: r.cpol, mosi: 1'b0, cs_n: 1'b0});
        write_reg(`SPI_ADDR_CS, 32'h1, 4'h1);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        logic [31:0] seed_draw;
        logic [31:0] st;
        int          base;
        resetn    = 1'b0;
        mmio_req  = '0;
        mode_cpol = 1'b0;
        mode_cpha = 1'b0;
        seed_draw = $urandom(32'h78d8a0f2);

        // cpol cpha div burst rand tx_bytes irqs
        rows[0] = '{1'b0, 1'b0, 3'd0, 4'd0, 1'b0, 32'h0000_00A5, 2'd1};
        rows[1] = '{1'b0, 1'b1, 3'd1, 4'd0, 1'b0, 32'h0000_003C, 2'd1};
        rows[2] = '{1'b1, 1'b0, 3'd2, 4'd0, 1'b1, 32'h0, 2'd1};
        rows[3] = '{1'b1, 1'b1, 3'd0, 4'd0, 1'b1, 32'h0, 2'd1};
        rows[4] = '{1'b0, 1'b0, 3'd3, 4'd0, 1'b1, 32'h0, 2'd1};
        rows[5] = '{1'b1, 1'b1, 3'd1, 4'd0, 1'b0, 32'h0000_0081, 2'd1};
        rows[6] = '{1'b0, 1'b1, 3'd7, 4'd0, 1'b0, 32'h0000_00C3, 2'd1};
        rows[7] = '{1'b0, 1'b1, 3'd2, 4'd3, 1'b1, 32'h0, 2'd1};
        rows[8] = '{1'b1, 1'b0, 3'd0, 4'd4, 1'b0, 32'h7FFE_0201, 2'd1};
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rand_fill) begin
                rows[i].tx_bytes = $urandom;
            end
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // Reset values, divider 7 in CTRL [4:2]
        read_check("CTRL reset", `SPI_ADDR_CTRL, 32'h0000_001C);
        read_check("CS reset", `SPI_ADDR_CS, 32'h1);
        read_check("STATUS reset", `SPI_ADDR_STATUS, 32'h2);
        read_check("BURST reset", `SPI_ADDR_BURST, 32'h0);
        check_pins("Reset pins", spi_pins, '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1});

        // Readback and lane gating
        write_reg(`SPI_ADDR_CS, 32'h0, 4'h1);
        read_check("CS write", `SPI_ADDR_CS, 32'h0);
        write_reg(`SPI_ADDR_CS, 32'h1, 4'h2);
        read_check("CS gated", `SPI_ADDR_CS, 32'h0);
        write_reg(`SPI_ADDR_CS, 32'h1, 4'h1);
        write_reg(`SPI_ADDR_CTRL, 32'h0000_000B, 4'h1);
        read_check("CTRL write", `SPI_ADDR_CTRL, 32'h0000_000B);
        write_reg(`SPI_ADDR_CTRL, 32'h0000_0014, 4'hE);
        read_check("CTRL gated", `SPI_ADDR_CTRL, 32'h0000_000B);
        // Unmapped word right after a nonzero read
        write_reg(32'h8000_0064, 32'hFFFF_FFFF, 4'hF);
        read_check("Unmapped", 32'h8000_0064, 32'h0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        // Back-pressure, mode 0 at /8
        base      = irq_count;
        mode_cpol = 1'b0;
        mode_cpha = 1'b0;
        write_reg(`SPI_ADDR_CTRL, 32'h0000_000C, 4'h1);
        write_reg(`SPI_ADDR_CS, 32'h0, 4'h1);
        write_reg(`SPI_ADDR_DATA, 32'h5A, 4'h1);
        read_check("STATUS busy", `SPI_ADDR_STATUS, 32'h1);
        // Held until the first byte is done
        write_reg(`SPI_ADDR_DATA, 32'hC3, 4'h1);
        check_irq_count("IRQ at blocked ack", irq_count, base + 1);
        wait_idle(st);
        read_check("DATA second byte", `SPI_ADDR_DATA, 32'hC3);
        check_slave_byte("MOSI both bytes", slave_rx, 8'hC3, slave_bits, 16);
        repeat (4) @(negedge clk);
        check_irq_count("IRQ after both bytes", irq_count, base + 2);
        write_reg(`SPI_ADDR_CS, 32'h1, 4'h1);

        $display("test passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/spi_pkg.sv
design/spi_clk_div.sv
design/spi_shift_engine.sv
design/spi_regs.sv
design/spi_master_top.sv
sim/tb_spi_master.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - include_dirs:
      - design
    files:
      - design/spi_pkg.sv
      - design/spi_clk_div.sv
      - design/spi_shift_engine.sv
      - design/spi_regs.sv
      - design/spi_master_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_spi_master.sv
